//--- sim.f
soc_ctrl_pkg.sv
soc_ctrl_pad_cfg.sv
soc_ctrl_watchdog.sv
soc_ctrl_rto.sv
soc_ctrl_apb_regs.sv
soc_ctrl_top.sv
tb_clk_gen.sv
tb_soc_ctrl.sv

//--- soc_ctrl_apb_regs.sv
// SoC control APB responder
// Four-state APB slave with address decode, the boot, fetch and JTAG
// registers, the selected pad index and the bootsel snapshot.
// Writes to the pad, watchdog and timeout blocks leave as one-cycle commands
`timescale 1ns/100ps

module soc_ctrl_apb_regs (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  soc_ctrl_pkg::apb_req_t              apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t              apb_rsp_o,
  input  logic                                sel_fll_clk_i,
  input  logic                                bootsel_i,
  input  logic                                dmactive_i,
  input  logic [soc_ctrl_pkg::JTAG_REG_W-1:0] soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::JTAG_REG_W-1:0] soc_jtag_reg_o,
  output logic [31:0]                         fc_bootaddr_o,
  output logic                                fc_fetchen_o,
  output logic                                soft_reset_o,
  output soc_ctrl_pkg::pad_wr_t               pad_wr_o,
  output logic [soc_ctrl_pkg::PAD_IDX_W-1:0]  pad_rd_idx_o,
  input  soc_ctrl_pkg::pad_entry_t            pad_rd_i,
  output soc_ctrl_pkg::wd_cmd_t               wd_cmd_o,
  input  soc_ctrl_pkg::wd_stat_t              wd_stat_i,
  output soc_ctrl_pkg::rto_cfg_t              rto_cfg_o,
  input  logic [soc_ctrl_pkg::RTO_CNT_W-1:0]  rto_count_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0]  rto_flags_i,
  output logic                                soft_rst_o
);
  import soc_ctrl_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, WRITE, WAIT} apb_state_e;

  apb_state_e            state_q;
  apb_rsp_t              rsp_q;
  logic [31:0]           bootaddr_q;
  logic                  fetchen_q;
  logic [JTAG_REG_W-1:0] jtag_out_q;
  logic [JTAG_REG_W-1:0] jtag_sync_q [2];
  logic [PAD_IDX_W-1:0]  pad_idx_q;     // Pad selected for indexed access
  logic [1:0]            bootsel_q;
  logic                  bootsel_done_q;
  logic                  soft_reset_q;

  logic [11:0] addr;
  logic        is_pad;
  logic        pad_in_range;
  logic        wr_en;
  logic        rd_err;
  logic        wr_err;
  logic [31:0] rdata;
  pad_word_u   wword;
  pad_word_u   rword;

  assign addr         = apb_req_i.paddr;
  assign wword        = apb_req_i.pwdata;
  assign is_pad       = (addr[11:10] == PAD_DIRECT_BASE[11:10]);
  assign pad_in_range = (addr[9:2] < N_IO);
  assign wr_en        = (state_q == WRITE);
  assign pad_rd_idx_o = is_pad ? addr[2 +: PAD_IDX_W] : pad_idx_q;

  always_comb begin
    rword  = '0;
    rdata  = '0;
    rd_err = 1'b0;
    if (is_pad) begin
      rword.direct.cfg = pad_rd_i.cfg;
      rword.direct.mux = pad_rd_i.mux;
      rdata = pad_in_range ? rword : PAD_OOR_RDATA;
    end else begin
      case (addr)
        REG_INFO:       rdata = {16'(NB_CORES), 16'(NB_CLUSTERS)};
        REG_FCBOOT:     rdata = bootaddr_q;
        REG_FCFETCH:    rdata = {31'b0, fetchen_q};
        REG_WCFGFUN, REG_RCFGFUN: begin
          rword.cfgfun.idx = pad_idx_q;
          rword.cfgfun.cfg = pad_rd_i.cfg;
          rword.cfgfun.mux = pad_rd_i.mux;
          rdata = rword;
        end
        REG_JTAGREG:    rdata = {16'b0, jtag_sync_q[1], jtag_out_q};
        REG_BOOTSEL:    rdata = {dmactive_i, bootsel_i, 28'b0, bootsel_q};
        REG_CLKSEL:     rdata = {31'b0, sel_fll_clk_i};
        REG_WD_COUNT:   rdata = {1'b0, wd_stat_i.count};
        REG_WD_CONTROL: rdata = {wd_stat_i.enabled, wd_stat_i.current};  // Live countdown
        REG_RTO_PERIPH: rdata = 32'(rto_flags_i);
        REG_RTO_COUNT:  rdata = 32'(rto_count_i);
        default: begin
          rd_err = 1'b1;
          rdata  = ERR_RDATA;
        end
      endcase
    end
  end

  // Out of range pad writes are dropped without an error
  assign wr_err = !is_pad && !(addr inside {REG_FCBOOT, REG_FCFETCH, REG_WCFGFUN,
                                            REG_RCFGFUN, REG_JTAGREG, REG_WD_COUNT,
                                            REG_WD_CONTROL, REG_RTO_PERIPH,
                                            REG_RTO_COUNT, REG_SOFT_RESET});

  always_comb begin
    pad_wr_o.valid = wr_en && (is_pad ? pad_in_range : (addr == REG_WCFGFUN));
    if (is_pad) begin
      pad_wr_o.idx       = addr[2 +: PAD_IDX_W];
      pad_wr_o.entry.cfg = wword.direct.cfg;
      pad_wr_o.entry.mux = wword.direct.mux;
    end else begin
      pad_wr_o.idx       = wword.cfgfun.idx;
      pad_wr_o.entry.cfg = wword.cfgfun.cfg;
      pad_wr_o.entry.mux = wword.cfgfun.mux;
    end
    wd_cmd_o.load_valid = wr_en && (addr == REG_WD_COUNT);
    wd_cmd_o.load_value = apb_req_i.pwdata[30:0];
    wd_cmd_o.enable     = wr_en && (addr == REG_WD_CONTROL) && apb_req_i.pwdata[0];
    wd_cmd_o.kick       = wr_en && (addr == REG_WD_CONTROL) &&
                          (apb_req_i.pwdata[15:0] == WD_KICK_KEY);
    rto_cfg_o.load      = wr_en && (addr == REG_RTO_COUNT);
    rto_cfg_o.value     = apb_req_i.pwdata[19:4];
    rto_cfg_o.clear     = wr_en && (addr == REG_RTO_PERIPH);
    soft_rst_o          = wr_en && (addr == REG_SOFT_RESET);
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= IDLE;
      rsp_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          rsp_q.pready  <= 1'b0;
          rsp_q.pslverr <= 1'b0;
          if (apb_req_i.psel && apb_req_i.penable) begin
            state_q <= apb_req_i.pwrite ? WRITE : READ;
          end
        end
        READ: begin
          rsp_q <= '{prdata: rdata, pready: 1'b1, pslverr: rd_err};
          state_q <= WAIT;
        end
        WRITE: begin
          rsp_q <= '{prdata: '0, pready: 1'b1, pslverr: wr_err};
          state_q <= WAIT;
        end
        default: begin  // WAIT lets the master drop psel
          rsp_q.pready  <= 1'b0;
          rsp_q.pslverr <= 1'b0;
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      bootaddr_q   <= BOOTADDR_RST;
      fetchen_q    <= 1'b1;  // Core fetches from reset
      jtag_out_q   <= '0;
      pad_idx_q    <= '0;
      soft_reset_q <= 1'b0;
    end else begin
      soft_reset_q <= soft_rst_o;
      if (wr_en) begin
        case (addr)
          REG_FCBOOT:               bootaddr_q <= apb_req_i.pwdata;
          REG_FCFETCH:              fetchen_q  <= apb_req_i.pwdata[0];
          REG_WCFGFUN, REG_RCFGFUN: pad_idx_q  <= wword.cfgfun.idx;
          REG_JTAGREG:              jtag_out_q <= apb_req_i.pwdata[JTAG_REG_W-1:0];
          REG_SOFT_RESET:           pad_idx_q  <= '0;
          default: begin
            if (is_pad && pad_in_range) pad_idx_q <= addr[2 +: PAD_IDX_W];
          end
        endcase
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      jtag_sync_q[0] <= '0;
      jtag_sync_q[1] <= '0;
      bootsel_q      <= '0;
      bootsel_done_q <= 1'b0;
    end else begin
      jtag_sync_q[0] <= soc_jtag_reg_i;
      jtag_sync_q[1] <= jtag_sync_q[0];
      if (!bootsel_done_q) begin  // Captured once after reset
        bootsel_q      <= {dmactive_i, bootsel_i};
        bootsel_done_q <= 1'b1;
      end
    end
  end

  assign apb_rsp_o      = rsp_q;
  assign fc_bootaddr_o  = bootaddr_q;
  assign fc_fetchen_o   = fetchen_q;
  assign soc_jtag_reg_o = jtag_out_q;
  assign soft_reset_o   = soft_reset_q;

  a_pready_single: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rsp_q.pready |=> !rsp_q.pready);

  a_one_cmd: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0({pad_wr_o.valid, wd_cmd_o.load_valid, wd_cmd_o.enable | wd_cmd_o.kick,
              rto_cfg_o.load, rto_cfg_o.clear, soft_rst_o}));

endmodule

//--- soc_ctrl_pad_cfg.sv
// Pad configuration storage
// Holds the config and mux setting of every IO pad, takes one indexed
// write per command and gives an indexed combinational read
`timescale 1ns/100ps

module soc_ctrl_pad_cfg (
  input  logic                                                        HCLK,
  input  logic                                                        HRESETn,
  input  soc_ctrl_pkg::pad_wr_t                                       pad_wr_i,
  input  logic                                                        soft_rst_i,
  input  logic [soc_ctrl_pkg::PAD_IDX_W-1:0]                          rd_idx_i,
  output soc_ctrl_pkg::pad_entry_t                                    rd_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::PADCFG_W-1:0] pad_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::PADMUX_W-1:0] pad_mux_o
);
  import soc_ctrl_pkg::*;

  pad_entry_t [N_IO-1:0] entry_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      entry_q <= {N_IO{PAD_ENTRY_RST}};
    end else if (soft_rst_i) begin
      entry_q <= {N_IO{PAD_ENTRY_RST}};  // Same defaults as power-up
    end else if (pad_wr_i.valid) begin
      entry_q[pad_wr_i.idx] <= pad_wr_i.entry;
    end
  end

  assign rd_o = entry_q[rd_idx_i];

  always_comb begin
    for (int i = 0; i < N_IO; i++) begin
      pad_cfg_o[i] = entry_q[i].cfg;
      pad_mux_o[i] = entry_q[i].mux;
    end
  end

endmodule

//--- soc_ctrl_pkg.sv
// SoC control block shared definitions
// Register map, field widths, reset values and the bundles that pass
// between the APB responder and the pad, watchdog and timeout blocks
package soc_ctrl_pkg;

  localparam int N_IO        = 32;
  localparam int PAD_IDX_W   = 5;
  localparam int PADCFG_W    = 6;
  localparam int PADMUX_W    = 2;
  localparam int NB_MASTER   = 4;
  localparam int JTAG_REG_W  = 8;
  localparam int NB_CORES    = 4;
  localparam int NB_CLUSTERS = 1;
  localparam int RTO_CNT_W   = 20;

  localparam logic [11:0] REG_INFO        = 12'h000;  // Cores in 31:16, clusters in 15:0
  localparam logic [11:0] REG_FCBOOT      = 12'h004;
  localparam logic [11:0] REG_FCFETCH     = 12'h008;
  localparam logic [11:0] REG_WCFGFUN     = 12'h060;  // Indexed pad write
  localparam logic [11:0] REG_RCFGFUN     = 12'h064;  // Indexed pad select for read
  localparam logic [11:0] REG_JTAGREG     = 12'h074;
  localparam logic [11:0] REG_BOOTSEL     = 12'h0C4;
  localparam logic [11:0] REG_CLKSEL      = 12'h0C8;
  localparam logic [11:0] REG_WD_COUNT    = 12'h0D0;
  localparam logic [11:0] REG_WD_CONTROL  = 12'h0D4;
  localparam logic [11:0] REG_RTO_PERIPH  = 12'h0E0;
  localparam logic [11:0] REG_RTO_COUNT   = 12'h0E4;
  localparam logic [11:0] REG_SOFT_RESET  = 12'h0FC;
  localparam logic [11:0] PAD_DIRECT_BASE = 12'h400;  // One word per pad up to 0x7FC

  localparam logic [31:0]          BOOTADDR_RST  = 32'h1A00_0080;
  localparam logic [30:0]          WD_COUNT_RST  = 31'd32768;
  localparam logic [RTO_CNT_W-1:0] RTO_COUNT_RST = 20'h000FF;
  localparam logic [15:0]          WD_KICK_KEY   = 16'h6699;
  localparam logic [31:0]          ERR_RDATA     = 32'hDEAD_BEEF;
  localparam logic [31:0]          PAD_OOR_RDATA = 32'h0095_BEEF;

  typedef struct packed {
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic        pwrite;
    logic        psel;
    logic        penable;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [1:0]           rsv_hi;
    logic [PADCFG_W-1:0]  cfg;     // 29:24
    logic [5:0]           rsv_mid;
    logic [PADMUX_W-1:0]  mux;     // 17:16
    logic [10:0]          rsv_lo;
    logic [PAD_IDX_W-1:0] idx;     // 4:0
  } pad_cfgfun_t;

  typedef struct packed {
    logic [17:0]          rsv_hi;
    logic [PADCFG_W-1:0]  cfg;     // 13:8
    logic [5:0]           rsv_lo;
    logic [PADMUX_W-1:0]  mux;     // 1:0
  } pad_direct_t;

  // Same bus word seen in the indexed format or the per-pad format
  typedef union packed {
    pad_cfgfun_t cfgfun;
    pad_direct_t direct;
  } pad_word_u;

  typedef struct packed {
    logic [PADCFG_W-1:0] cfg;
    logic [PADMUX_W-1:0] mux;
  } pad_entry_t;

  localparam pad_entry_t PAD_ENTRY_RST = '{cfg: '1, mux: '0};

  typedef struct packed {
    logic                 valid;
    logic [PAD_IDX_W-1:0] idx;
    pad_entry_t           entry;
  } pad_wr_t;

  typedef struct packed {
    logic        load_valid;
    logic [30:0] load_value;
    logic        enable;
    logic        kick;        // Key already matched
  } wd_cmd_t;

  typedef struct packed {
    logic [30:0] count;
    logic [30:0] current;
    logic        enabled;
    logic        expired;
  } wd_stat_t;

  typedef struct packed {
    logic        load;
    logic [15:0] value;  // Written bits 19:4
    logic        clear;  // Empties the sticky flags
  } rto_cfg_t;

endpackage

//--- soc_ctrl_rto.sv
// Bus ready-timeout monitor
// Down-counter that runs while a transfer waits and flags a timeout at
// zero, plus sticky per-master timeout flags
`timescale 1ns/100ps

module soc_ctrl_rto (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               start_rto_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0] peripheral_rto_i,
  input  soc_ctrl_pkg::rto_cfg_t             rto_cfg_i,
  input  logic                               soft_rst_i,
  output logic [soc_ctrl_pkg::RTO_CNT_W-1:0] rto_count_o,
  output logic [soc_ctrl_pkg::NB_MASTER-1:0] rto_flags_o,
  output logic                               rto_o
);
  import soc_ctrl_pkg::*;

  logic [RTO_CNT_W-1:0] reload_q;
  logic [RTO_CNT_W-1:0] count_q;
  logic [NB_MASTER-1:0] flags_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      reload_q <= RTO_COUNT_RST;
      count_q  <= RTO_COUNT_RST;
      flags_q  <= '0;
      rto_o    <= 1'b0;
    end else begin
      count_q <= start_rto_i ? count_q - 1'b1 : reload_q;
      rto_o   <= (count_q == '0);
      if (soft_rst_i) begin
        reload_q <= RTO_COUNT_RST;
        flags_q  <= '0;
      end else begin
        if (rto_cfg_i.load) begin
          reload_q <= {rto_cfg_i.value, 4'hF};  // Low nibble always set
        end
        flags_q <= rto_cfg_i.clear ? '0 : (flags_q | peripheral_rto_i);
      end
    end
  end

  assign rto_count_o = reload_q;
  assign rto_flags_o = flags_q;

endmodule

//--- soc_ctrl_top.sv
// SoC control block top level
// Connects the APB responder to the pad configuration, watchdog and
// ready-timeout blocks and to the subsystem pins
`timescale 1ns/100ps

module soc_ctrl_top (
  input  logic                                                        HCLK,
  input  logic                                                        HRESETn,
  input  soc_ctrl_pkg::apb_req_t                                      apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t                                      apb_rsp_o,
  input  logic                                                        sel_fll_clk_i,
  input  logic                                                        bootsel_i,
  input  logic                                                        dmactive_i,
  input  logic                                                        ref_clk_i,
  input  logic                                                        stoptimer_i,
  input  logic                                                        start_rto_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0]                          peripheral_rto_i,
  input  logic [soc_ctrl_pkg::JTAG_REG_W-1:0]                         soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::JTAG_REG_W-1:0]                         soc_jtag_reg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::PADCFG_W-1:0] pad_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::PADMUX_W-1:0] pad_mux_o,
  output logic [31:0]                                                 fc_bootaddr_o,
  output logic                                                        fc_fetchen_o,
  output logic                                                        wd_expired_o,
  output logic                                                        rto_o,
  output logic                                                        soft_reset_o
);
  import soc_ctrl_pkg::*;

  pad_wr_t              pad_wr;
  logic [PAD_IDX_W-1:0] pad_rd_idx;
  pad_entry_t           pad_rd;
  wd_cmd_t              wd_cmd;
  wd_stat_t             wd_stat;
  rto_cfg_t             rto_cfg;
  logic [RTO_CNT_W-1:0] rto_count;
  logic [NB_MASTER-1:0] rto_flags;
  logic                 soft_rst;   // Internal strobe, same cycle as the write

  soc_ctrl_apb_regs u_regs (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .apb_req_i      (apb_req_i),
    .apb_rsp_o      (apb_rsp_o),
    .sel_fll_clk_i  (sel_fll_clk_i),
    .bootsel_i      (bootsel_i),
    .dmactive_i     (dmactive_i),
    .soc_jtag_reg_i (soc_jtag_reg_i),
    .soc_jtag_reg_o (soc_jtag_reg_o),
    .fc_bootaddr_o  (fc_bootaddr_o),
    .fc_fetchen_o   (fc_fetchen_o),
    .soft_reset_o   (soft_reset_o),
    .pad_wr_o       (pad_wr),
    .pad_rd_idx_o   (pad_rd_idx),
    .pad_rd_i       (pad_rd),
    .wd_cmd_o       (wd_cmd),
    .wd_stat_i      (wd_stat),
    .rto_cfg_o      (rto_cfg),
    .rto_count_i    (rto_count),
    .rto_flags_i    (rto_flags),
    .soft_rst_o     (soft_rst)
  );

  soc_ctrl_pad_cfg u_pad_cfg (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .pad_wr_i   (pad_wr),
    .soft_rst_i (soft_rst),
    .rd_idx_i   (pad_rd_idx),
    .rd_o       (pad_rd),
    .pad_cfg_o  (pad_cfg_o),
    .pad_mux_o  (pad_mux_o)
  );

  soc_ctrl_watchdog u_watchdog (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .ref_clk_i    (ref_clk_i),
    .stoptimer_i  (stoptimer_i),
    .wd_cmd_i     (wd_cmd),
    .wd_stat_o    (wd_stat),
    .wd_expired_o (wd_expired_o)
  );

  soc_ctrl_rto u_rto (
    .HCLK             (HCLK),
    .HRESETn          (HRESETn),
    .start_rto_i      (start_rto_i),
    .peripheral_rto_i (peripheral_rto_i),
    .rto_cfg_i        (rto_cfg),
    .soft_rst_i       (soft_rst),
    .rto_count_o      (rto_count),
    .rto_flags_o      (rto_flags),
    .rto_o            (rto_o)
  );

endmodule

//--- soc_ctrl_watchdog.sv
// Watchdog timer
// Counts down on rising edges of the slow reference clock once enabled.
// Keyed kicks reload the count, expiry is sticky until reset
`timescale 1ns/100ps

module soc_ctrl_watchdog (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   ref_clk_i,
  input  logic                   stoptimer_i,
  input  soc_ctrl_pkg::wd_cmd_t  wd_cmd_i,
  output soc_ctrl_pkg::wd_stat_t wd_stat_o,
  output logic                   wd_expired_o
);
  import soc_ctrl_pkg::*;

  logic [2:0] ref_q;   // Two sync stages, then the edge-detect stage
  logic       tick_q;
  wd_stat_t   stat_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ref_q  <= '0;
      tick_q <= 1'b0;
    end else begin
      ref_q  <= {ref_q[1:0], ref_clk_i};
      tick_q <= ref_q[1] & ~ref_q[2];
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      stat_q <= '{count: WD_COUNT_RST, current: WD_COUNT_RST, enabled: 1'b0, expired: 1'b0};
    end else begin
      if (wd_cmd_i.load_valid && !stat_q.enabled) begin
        stat_q.count <= wd_cmd_i.load_value;  // Locked once running
      end
      if (!stat_q.enabled) begin
        if (wd_cmd_i.enable) begin
          stat_q.enabled <= 1'b1;
          stat_q.current <= stat_q.count;
        end
      end else if (wd_cmd_i.kick) begin
        stat_q.current <= stat_q.count;
      end else if (tick_q && !stoptimer_i && (stat_q.current != '0)) begin
        stat_q.current <= stat_q.current - 1'b1;
      end
      if (stat_q.enabled && (stat_q.current == '0)) begin
        stat_q.expired <= 1'b1;
      end
    end
  end

  assign wd_stat_o    = stat_q;
  assign wd_expired_o = stat_q.expired;

  a_current_no_rise: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (stat_q.current > $past(stat_q.current)) |-> $past(wd_cmd_i.enable || wd_cmd_i.kick));

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset source
// 8 ns clock, active-low reset held over the first 5 rising edges
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // Released just after an edge
  end

endmodule

//--- tb_soc_ctrl.sv
// SoC control block testbench
// Directed tests over APB for the registers, pads, watchdog, ready
// timeout and soft reset, with a cycle limit on the whole run
`timescale 1ns/100ps

module tb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int RUN_LIMIT = 4000;  // Tests take well under 1000 cycles
  localparam logic [31:0] NEW_BOOT = 32'h1C00_8000;

  logic                           HCLK;
  logic                           HRESETn;
  apb_req_t                       apb_req;
  apb_rsp_t                       apb_rsp;
  logic                           sel_fll_clk;
  logic                           bootsel;
  logic                           dmactive;
  logic                           ref_clk;
  logic                           stoptimer;
  logic                           start_rto;
  logic [NB_MASTER-1:0]           periph_rto;
  logic [JTAG_REG_W-1:0]          jtag_in;
  logic [JTAG_REG_W-1:0]          jtag_out;
  logic [N_IO-1:0][PADCFG_W-1:0]  pad_cfg;
  logic [N_IO-1:0][PADMUX_W-1:0]  pad_mux;
  logic [31:0]                    fc_bootaddr;
  logic                           fc_fetchen;
  logic                           wd_expired;
  logic                           rto;
  logic                           soft_reset;

  pad_entry_t pad_model [N_IO];  // Expected setting of every pad
  integer     seed = 82;
  int         errors;
  int         checks;
  int         tests;
  int         test_err_base;
  int         cycle_cnt;
  string      test_name;

  tb_clk_gen u_clk_gen (
    .clk_o   (HCLK),
    .rst_n_o (HRESETn)
  );

  soc_ctrl_top dut0 (
    .HCLK             (HCLK),
    .HRESETn          (HRESETn),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .sel_fll_clk_i    (sel_fll_clk),
    .bootsel_i        (bootsel),
    .dmactive_i       (dmactive),
    .ref_clk_i        (ref_clk),
    .stoptimer_i      (stoptimer),
    .start_rto_i      (start_rto),
    .peripheral_rto_i (periph_rto),
    .soc_jtag_reg_i   (jtag_in),
    .soc_jtag_reg_o   (jtag_out),
    .pad_cfg_o        (pad_cfg),
    .pad_mux_o        (pad_mux),
    .fc_bootaddr_o    (fc_bootaddr),
    .fc_fetchen_o     (fc_fetchen),
    .wd_expired_o     (wd_expired),
    .rto_o            (rto),
    .soft_reset_o     (soft_reset)
  );

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s prdata %h pready %h pslverr %h expected %h %h %h", name,
               got.prdata, got.pready, got.pslverr, exp.prdata, exp.pready, exp.pslverr);
    end
  endtask

  task automatic check_pad(input string name, input pad_entry_t got, input pad_entry_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s cfg %h mux %h expected cfg %h mux %h", name,
               got.cfg, got.mux, exp.cfg, exp.mux);
    end
  endtask

  function automatic apb_rsp_t ok_rsp(input logic [31:0] data);
    return '{prdata: data, pready: 1'b1, pslverr: 1'b0};
  endfunction

  function automatic pad_entry_t pad_out(input int idx);
    pad_entry_t e;
    e.cfg = pad_cfg[idx];
    e.mux = pad_mux[idx];
    return e;
  endfunction

  // Called 1 ns after an edge, returns 1 ns after the edge that shows pready
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output apb_rsp_t rsp);
    int cycles;
    cycles = 0;
    apb_req = '{paddr: addr, pwdata: wdata, pwrite: wr, psel: 1'b1, penable: 1'b0};
    @(posedge HCLK);
    #1;
    apb_req.penable = 1'b1;
    do begin
      @(posedge HCLK);
      #1;
      cycles++;
    end while (!apb_rsp.pready && cycles < 16);
    rsp = apb_rsp;
    if (!apb_rsp.pready) begin
      errors++;
      $display("No pready within 16 cycles for access to address %h", addr);
    end else begin
      check_word($sformatf("pready latency at %h", addr), cycles, 2);
    end
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    apb_rsp_t rsp;
    apb_access(1'b1, addr, data, rsp);
    check_rsp($sformatf("write response at %h", addr), rsp, ok_rsp(32'h0));
  endtask

  task automatic apb_read(input logic [11:0] addr, output apb_rsp_t rsp);
    apb_access(1'b0, addr, 32'h0, rsp);
  endtask

  task automatic read_check(input string name, input logic [11:0] addr, input logic [31:0] exp);
    apb_rsp_t rsp;
    apb_read(addr, rsp);
    check_rsp(name, rsp, ok_rsp(exp));
  endtask

  task automatic check_all_pads(input string name);
    for (int i = 0; i < N_IO; i++) begin
      check_pad($sformatf("%s pad_cfg_o/pad_mux_o[%0d]", name, i), pad_out(i), pad_model[i]);
    end
  endtask

  // One rising edge of the slow reference clock, long enough to be synchronized
  task automatic ref_tick();
    ref_clk = 1'b1;
    repeat (4) @(posedge HCLK);
    #1 ref_clk = 1'b0;
    repeat (4) @(posedge HCLK);
    #1;
  endtask

  // Holds start_rto_i until rto_o rises and returns the cycles it took
  task automatic run_rto(output int n);
    n = 0;
    start_rto = 1'b1;
    do begin
      @(posedge HCLK);
      #1;
      n++;
    end while (!rto && n < 100);
    start_rto = 1'b0;
  endtask

  task automatic start_test(input string name);
    tests++;
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic finish_test();
    $display("Test %0d %s finished with %0d errors", tests, test_name, errors - test_err_base);
  endtask

  task automatic test_reset_defaults();
    start_test("reset defaults");
    read_check("INFO", REG_INFO, 32'h0004_0001);  // 4 cores, 1 cluster
    read_check("FCBOOT", REG_FCBOOT, BOOTADDR_RST);
    read_check("FCFETCH", REG_FCFETCH, 32'h1);
    check_word("fc_bootaddr_o", fc_bootaddr, BOOTADDR_RST);
    check_word("fc_fetchen_o", 32'(fc_fetchen), 32'h1);
    check_all_pads("reset");
    check_word("wd_expired_o", 32'(wd_expired), 32'h0);
    check_word("rto_o", 32'(rto), 32'h0);
    check_word("soft_reset_o", 32'(soft_reset), 32'h0);
    finish_test();
  endtask

  task automatic test_registers();
    apb_rsp_t rsp;
    start_test("registers and errors");
    apb_write(REG_FCBOOT, NEW_BOOT);
    read_check("FCBOOT", REG_FCBOOT, NEW_BOOT);
    check_word("fc_bootaddr_o", fc_bootaddr, NEW_BOOT);
    apb_write(REG_JTAGREG, 32'h0000_00A5);
    jtag_in = 8'h3C;
    repeat (2) @(posedge HCLK);  // Two-flop synchronizer
    #1;
    read_check("JTAGREG", REG_JTAGREG, 32'h0000_3CA5);  // Input in 15:8, written byte in 7:0
    check_word("soc_jtag_reg_o", 32'(jtag_out), 32'hA5);
    apb_read(12'h010, rsp);
    check_rsp("unmapped read", rsp, '{prdata: ERR_RDATA, pready: 1'b1, pslverr: 1'b1});
    finish_test();
  endtask

  task automatic test_pads();
    logic [31:0]          r;
    logic [31:0]          word;
    logic [11:0]          addr;
    logic [PAD_IDX_W-1:0] idx;
    pad_entry_t           e;
    start_test("pad configuration");
    for (int k = 0; k < 4; k++) begin
      r     = $random(seed);
      idx   = r[4:0];
      e.cfg = r[13:8];
      e.mux = r[17:16];
      word  = {2'b00, e.cfg, 6'b0, e.mux, 11'b0, idx};  // Indexed format
      apb_write(REG_WCFGFUN, word);
      pad_model[idx] = e;
      check_pad($sformatf("cfgfun pad %0d", idx), pad_out(idx), e);
      read_check("RCFGFUN", REG_RCFGFUN, word);
    end
    for (int k = 0; k < 4; k++) begin
      r     = $random(seed);
      idx   = r[4:0];
      e.cfg = r[13:8];
      e.mux = r[17:16];
      word  = {18'b0, e.cfg, 6'b0, e.mux};  // Per-pad format
      addr  = PAD_DIRECT_BASE + 12'(idx) * 12'd4;
      apb_write(addr, word);
      pad_model[idx] = e;
      check_pad($sformatf("direct pad %0d", idx), pad_out(idx), e);
      read_check("direct pad read", addr, word);
    end
    check_all_pads("after writes");
    apb_write(PAD_DIRECT_BASE + 12'd160, 32'h0000_3F03);  // Index 40 is beyond the pads
    check_all_pads("after index 40");
    read_check("pad index 40", PAD_DIRECT_BASE + 12'd160, PAD_OOR_RDATA);
    finish_test();
  endtask

  task automatic test_watchdog();
    start_test("watchdog");
    apb_write(REG_WD_COUNT, 32'd4);
    read_check("WD_COUNT", REG_WD_COUNT, 32'd4);
    apb_write(REG_WD_CONTROL, 32'h1);
    read_check("WD_CONTROL after enable", REG_WD_CONTROL, 32'h8000_0004);
    repeat (3) ref_tick();
    read_check("WD_CONTROL after 3 ticks", REG_WD_CONTROL, 32'h8000_0001);
    check_word("wd_expired_o before kick", 32'(wd_expired), 32'h0);
    apb_write(REG_WD_CONTROL, 32'(WD_KICK_KEY));
    read_check("WD_CONTROL after kick", REG_WD_CONTROL, 32'h8000_0004);
    repeat (3) ref_tick();
    check_word("wd_expired_o 3 ticks after kick", 32'(wd_expired), 32'h0);
    apb_write(REG_WD_CONTROL, 32'h0000_6698);
    read_check("WD_CONTROL after wrong key", REG_WD_CONTROL, 32'h8000_0001);
    ref_tick();  // Fourth tick since the kick
    check_word("wd_expired_o after 4 ticks", 32'(wd_expired), 32'h1);
    apb_write(REG_WD_CONTROL, 32'(WD_KICK_KEY));  // Reloads the count after expiry
    read_check("WD_CONTROL after late kick", REG_WD_CONTROL, 32'h8000_0004);
    check_word("wd_expired_o sticky", 32'(wd_expired), 32'h1);
    finish_test();
  endtask

  task automatic test_timeout();
    int n;
    start_test("ready timeout");
    apb_write(REG_RTO_COUNT, 32'h20);
    read_check("RTO_COUNT", REG_RTO_COUNT, 32'h2F);  // Bits 19:4 kept, low nibble set
    run_rto(n);
    check_word("rto_o delay in cycles", n, 48);
    @(posedge HCLK);
    #1;
    check_word("rto_o after start drops", 32'(rto), 32'h0);
    start_rto = 1'b1;  // Partial count that the reload must undo
    repeat (10) @(posedge HCLK);
    #1 start_rto = 1'b0;
    @(posedge HCLK);
    #1;
    run_rto(n);
    check_word("rto_o delay after reload", n, 48);
    periph_rto = 4'b0100;
    @(posedge HCLK);
    #1 periph_rto = '0;
    read_check("RTO_PERIPH flag", REG_RTO_PERIPH, 32'h4);
    apb_write(REG_RTO_PERIPH, 32'h0);
    read_check("RTO_PERIPH after clear", REG_RTO_PERIPH, 32'h0);
    finish_test();
  endtask

  task automatic test_soft_reset();
    start_test("soft reset");
    apb_write(PAD_DIRECT_BASE + 12'h00C, 32'h0000_1502);  // Pad 3, cfg 0x15, mux 2
    pad_model[3] = '{cfg: 6'h15, mux: 2'h2};
    check_all_pads("before soft reset");
    apb_write(REG_RTO_COUNT, 32'h100);
    read_check("RTO_COUNT before soft reset", REG_RTO_COUNT, 32'h10F);
    periph_rto = 4'b0001;
    @(posedge HCLK);
    #1 periph_rto = '0;
    apb_write(REG_SOFT_RESET, 32'h1);
    check_word("soft_reset_o pulse", 32'(soft_reset), 32'h1);
    @(posedge HCLK);
    #1;
    check_word("soft_reset_o after pulse", 32'(soft_reset), 32'h0);
    for (int i = 0; i < N_IO; i++) begin
      pad_model[i] = '{cfg: '1, mux: '0};
    end
    check_all_pads("after soft reset");
    read_check("RTO_COUNT after soft reset", REG_RTO_COUNT, 32'(RTO_COUNT_RST));
    read_check("RTO_PERIPH after soft reset", REG_RTO_PERIPH, 32'h0);
    read_check("FCBOOT after soft reset", REG_FCBOOT, NEW_BOOT);
    check_word("fc_bootaddr_o after soft reset", fc_bootaddr, NEW_BOOT);
    finish_test();
  endtask

  always @(posedge HCLK) begin
    cycle_cnt++;
    if (cycle_cnt >= RUN_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", RUN_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    apb_req     = '0;
    sel_fll_clk = 1'b0;
    bootsel     = 1'b0;
    dmactive    = 1'b0;
    ref_clk     = 1'b0;
    stoptimer   = 1'b0;
    start_rto   = 1'b0;
    periph_rto  = '0;
    jtag_in     = '0;
    for (int i = 0; i < N_IO; i++) begin
      pad_model[i] = '{cfg: '1, mux: '0};
    end
    @(posedge HRESETn);
    @(posedge HCLK);
    #1;
    test_reset_defaults();
    test_registers();
    test_pads();
    test_watchdog();
    test_timeout();
    test_soft_reset();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
